// File: Makefile
# Verilator build and run for the serial bus memory slave testbench

VERILATOR ?= verilator
SIM_TOP   ?= bus_slave_tb
TRACE     ?= 0
OBJ_DIR   ?= obj_dir
FILE_LIST ?= src.f

VFLAGS := --binary --timing --assert --timescale 1ns/1ps -j 0

ifeq ($(TRACE),1)
VFLAGS += --trace
endif

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR=$(VERILATOR) SIM_TOP=$(SIM_TOP) TRACE=$(TRACE)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(SIM_TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)
	./$(OBJ_DIR)/V$(SIM_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/bus_frame_pkg.sv
// serial command frame layout, imported by the frame decoder, the top level and the testbench

package bus_frame_pkg;

    import slave_mem_pkg::ADDR_WIDTH;

    // start code sits in the first bits of every frame
    localparam int START_WIDTH = 3;
    localparam logic [START_WIDTH-1:0] START_PATTERN = '1;

    // slave id field follows the start code
    localparam int ID_WIDTH = 2;

    // start | id | rw | burst | address, sent msb first
    localparam int FRAME_LEN = START_WIDTH + ID_WIDTH + 2 + ADDR_WIDTH;

    // bit positions inside a complete frame, bit 0 is the last bit on the wire
    localparam int BURST_POS = ADDR_WIDTH;
    localparam int RW_POS    = ADDR_WIDTH + 1;
    localparam int ID_LSB    = ADDR_WIDTH + 2;
    localparam int START_LSB = ID_LSB + ID_WIDTH;

    // rw bit value that asks for a write, zero asks for a read
    localparam logic RW_WRITE = 1'b1;

    typedef logic [ID_WIDTH-1:0] slave_id_t;

endpackage : bus_frame_pkg

// File: hdl/bus_slave_top.sv
// serial bus memory slave top level, connects the frame decoder, transfer controller and memory

`timescale 1ns/1ps

module bus_slave_top
    import bus_frame_pkg::*, slave_mem_pkg::*;
#(
    parameter slave_id_t SLAVE_ID  = 1,
    parameter int        MEM_DEPTH = 256
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wr_data,
    input  logic valid,
    input  logic last,
    output logic rd_data,
    output logic ready
);

    // decoded command towards the controller
    logic  cmd_strobe;
    logic  cmd_write;
    logic  cmd_burst;
    addr_t cmd_addr;
    logic  busy;

    // memory port
    logic  mem_we;
    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;

    frame_decoder #(
        .SLAVE_ID (SLAVE_ID)
    ) u_frame_decoder (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .busy       (busy),
        .cmd_strobe (cmd_strobe),
        .cmd_write  (cmd_write),
        .cmd_burst  (cmd_burst),
        .cmd_addr   (cmd_addr)
    );

    transfer_ctrl #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_transfer_ctrl (
        .clk        (clk),
        .rstN       (rstN),
        .cmd_strobe (cmd_strobe),
        .cmd_write  (cmd_write),
        .cmd_burst  (cmd_burst),
        .cmd_addr   (cmd_addr),
        .wr_data    (wr_data),
        .valid      (valid),
        .last       (last),
        .mem_rdata  (mem_rdata),
        .busy       (busy),
        .ready      (ready),
        .rd_data    (rd_data),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    slave_mem #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_slave_mem (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule : bus_slave_top

// File: hdl/frame_decoder.sv
// command frame decoder, shifts in the control line and strobes one decoded command per match

`timescale 1ns/1ps

module frame_decoder
    import bus_frame_pkg::*, slave_mem_pkg::*;
#(
    parameter slave_id_t SLAVE_ID = 1
) (
    input  logic  clk,
    input  logic  rstN,
    input  logic  control,
    input  logic  busy,
    output logic  cmd_strobe,
    output logic  cmd_write,
    output logic  cmd_burst,
    output addr_t cmd_addr
);

    localparam int CNT_W = $clog2(FRAME_LEN);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(FRAME_LEN - 1);

    // high from the first start bit until the last frame bit is sampled
    logic                 in_frame;
    logic [CNT_W-1:0]     bit_cnt;

    // earlier frame bits, the current control bit completes the frame
    logic [FRAME_LEN-2:0] frame_sr;
    logic [FRAME_LEN-1:0] frame;

    logic                 hunt_start;
    logic                 frame_done;
    logic                 frame_ok;

    assign frame = {frame_sr, control};

    // no new frame while a transfer runs or a command is being handed over
    assign hunt_start = !in_frame && !busy && !cmd_strobe && control;

    assign frame_done = in_frame && (bit_cnt == LAST_BIT);

    assign frame_ok = (frame[START_LSB +: START_WIDTH] == START_PATTERN) &&
                      (frame[ID_LSB +: ID_WIDTH] == SLAVE_ID);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            in_frame   <= 1'b0;
            bit_cnt    <= '0;
            cmd_strobe <= 1'b0;
        end else begin
            cmd_strobe <= 1'b0;
            if (in_frame) begin
                if (frame_done) begin
                    // a bad start code or another slave id just drops the frame
                    in_frame   <= 1'b0;
                    bit_cnt    <= '0;
                    cmd_strobe <= frame_ok;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (hunt_start) begin
                // this edge already took the first start bit
                in_frame <= 1'b1;
                bit_cnt  <= CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hunt_start || in_frame) begin
            frame_sr <= frame[FRAME_LEN-2:0];
        end
        // fields are held until the next frame completes
        if (frame_done) begin
            cmd_write <= (frame[RW_POS] == RW_WRITE);
            cmd_burst <= frame[BURST_POS];
            cmd_addr  <= frame[ADDR_WIDTH-1:0];
        end
    end

    // one strobe per frame, frames are at least FRAME_LEN cycles apart
    a_strobe_single: assert property (
        @(posedge clk) disable iff (!rstN)
        cmd_strobe |=> !cmd_strobe
    ) else $error("cmd_strobe held for more than one cycle");

    // the controller must have been idle when the frame ended
    a_strobe_not_busy: assert property (
        @(posedge clk) disable iff (!rstN)
        cmd_strobe |-> !busy
    ) else $error("cmd_strobe fired during a running transfer");

endmodule : frame_decoder

// File: hdl/slave_mem.sv
// on-chip word memory of the bus slave, one port with synchronous write and registered read

`timescale 1ns/1ps

module slave_mem
    import slave_mem_pkg::*;
#(
    parameter int MEM_DEPTH = 256
) (
    input  logic  clk,
    input  logic  mem_we,
    input  addr_t mem_addr,
    input  word_t mem_wdata,
    output word_t mem_rdata
);

    // contents start undefined
    word_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // read-first, data follows the address by one cycle
    always_ff @(posedge clk) begin
        mem_rdata <= mem[mem_addr];
    end

endmodule : slave_mem

// File: hdl/slave_mem_pkg.sv
// memory storage definitions, imported by the memory, the controller and anything moving words

package slave_mem_pkg;

    // word size carried on the serial data lines
    localparam int DATA_WIDTH = 32;

    // address field of the command frame, also the widest memory index
    localparam int ADDR_WIDTH = 8;

    // largest memory that the address field can reach
    localparam int MAX_DEPTH = 1 << ADDR_WIDTH;

    // one stored word
    typedef logic [DATA_WIDTH-1:0] word_t;

    // one memory address
    typedef logic [ADDR_WIDTH-1:0] addr_t;

endpackage : slave_mem_pkg

// File: hdl/transfer_ctrl.sv
// transfer controller, moves words between the serial data lines and the memory after a command

`timescale 1ns/1ps

module transfer_ctrl
    import slave_mem_pkg::*;
#(
    parameter int MEM_DEPTH = 256
) (
    input  logic  clk,
    input  logic  rstN,
    input  logic  cmd_strobe,
    input  logic  cmd_write,
    input  logic  cmd_burst,
    input  addr_t cmd_addr,
    input  logic  wr_data,
    input  logic  valid,
    input  logic  last,
    input  word_t mem_rdata,
    output logic  busy,
    output logic  ready,
    output logic  rd_data,
    output logic  mem_we,
    output addr_t mem_addr,
    output word_t mem_wdata
);

    localparam int CNT_W = $clog2(DATA_WIDTH);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DATA_WIDTH - 1);

    // fetch presents the address, load catches the registered memory output
    typedef enum logic [2:0] {
        idle,
        fetch,
        load,
        send,
        receive,
        store
    } state_t;

    state_t           state;
    addr_t            addr_cnt;
    addr_t            addr_next;
    logic [CNT_W-1:0] bit_cnt;
    logic             burst_q;
    // set when the word waiting in store ends the transfer
    logic             final_q;
    word_t            rd_sr;
    word_t            wr_sr;
    logic             take_bit;

    assign addr_next = (addr_cnt == addr_t'(MEM_DEPTH - 1)) ? '0 : addr_cnt + 1'b1;

    // the master keeps streaming during store, so the next word's first bit lands there
    assign take_bit = valid && ((state == receive) || (state == store && !final_q));

    assign busy      = (state != idle);
    assign ready     = (state == send);
    assign rd_data   = ready && rd_sr[DATA_WIDTH-1];
    assign mem_we    = (state == store);
    assign mem_addr  = addr_cnt;
    assign mem_wdata = wr_sr;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= idle;
            addr_cnt <= '0;
            bit_cnt  <= '0;
            burst_q  <= 1'b0;
            final_q  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (cmd_strobe) begin
                        // fold a start address beyond the memory back into range
                        addr_cnt <= addr_t'(int'(cmd_addr) % MEM_DEPTH);
                        burst_q  <= cmd_burst;
                        bit_cnt  <= '0;
                        state    <= cmd_write ? receive : fetch;
                    end
                end
                fetch: begin
                    state <= load;
                end
                load: begin
                    bit_cnt <= '0;
                    state   <= send;
                end
                send: begin
                    if (bit_cnt == LAST_BIT) begin
                        bit_cnt <= '0;
                        // last is read together with the final bit of the word
                        if (burst_q && !last) begin
                            addr_cnt <= addr_next;
                            state    <= fetch;
                        end else begin
                            state <= idle;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                receive: begin
                    if (valid) begin
                        if (bit_cnt == LAST_BIT) begin
                            bit_cnt <= '0;
                            final_q <= !burst_q || last;
                            state   <= store;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                store: begin
                    if (final_q) begin
                        state <= idle;
                    end else begin
                        addr_cnt <= addr_next;
                        bit_cnt  <= valid ? CNT_W'(1) : '0;
                        state    <= receive;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // shift registers carry payload only
    always_ff @(posedge clk) begin
        if (state == load) begin
            rd_sr <= mem_rdata;
        end else if (state == send) begin
            rd_sr <= rd_sr << 1;
        end
        if (take_bit) begin
            wr_sr <= {wr_sr[DATA_WIDTH-2:0], wr_data};
        end
    end

    // wrap logic and start folding keep every access inside the array
    a_addr_in_range: assert property (
        @(posedge clk) disable iff (!rstN)
        int'(mem_addr) < MEM_DEPTH
    ) else $error("memory address %0d beyond depth %0d", mem_addr, MEM_DEPTH);

    // read bits only appear inside a transfer seen by the decoder
    a_ready_in_transfer: assert property (
        @(posedge clk) disable iff (!rstN)
        ready |-> busy
    ) else $error("ready high outside a transfer");

endmodule : transfer_ctrl

// File: src.f
hdl/slave_mem_pkg.sv
hdl/bus_frame_pkg.sv
hdl/frame_decoder.sv
hdl/transfer_ctrl.sv
hdl/slave_mem.sv
hdl/bus_slave_top.sv
test/bus_slave_tb.sv

// File: test/bus_slave_tb.sv
// testbench for the serial bus memory slave, runs a table of transfers against a reference memory

`timescale 1ns/1ps

module bus_slave_tb
    import bus_frame_pkg::*, slave_mem_pkg::*;
();

    localparam slave_id_t SLAVE_ID  = 2'd1;
    localparam int        MEM_DEPTH = 256;
    // edges from the last frame bit to the first read bit
    localparam int        LATENCY   = 3;
    // ready low cycles between words of a burst read
    localparam int        WORD_GAP  = 2;

    logic clk;
    logic rstN;
    logic control;
    logic wr_data;
    logic valid;
    logic last;
    logic rd_data;
    logic ready;

    // stimulus table, one entry per transfer
    string     name_q[$];
    bit        write_q[$];
    slave_id_t id_q[$];
    bit        burst_q[$];
    addr_t     addr_q[$];
    int        words_q[$];
    bit        gap_q[$];

    // reference memory, only matching writes land here
    word_t       ref_mem [MEM_DEPTH];
    bit          ref_known [MEM_DEPTH];

    logic [31:0] lfsr_state;
    int          cycle_cnt;
    int          cycle_limit;

    bus_slave_top #(
        .SLAVE_ID  (SLAVE_ID),
        .MEM_DEPTH (MEM_DEPTH)
    ) uut (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wr_data (wr_data),
        .valid   (valid),
        .last    (last),
        .rd_data (rd_data),
        .ready   (ready)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            stop_run($sformatf("run timed out after %0d cycles", cycle_cnt));
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            stop_run($sformatf("MISMATCH %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // inputs change 2 ns after the rising edge, outputs are sampled there too
    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic add_entry(input string name, input bit write, input slave_id_t id,
                             input bit burst, input addr_t addr, input int words,
                             input bit gap);
        name_q.push_back(name);
        write_q.push_back(write);
        id_q.push_back(id);
        burst_q.push_back(burst);
        addr_q.push_back(addr);
        words_q.push_back(words);
        gap_q.push_back(gap);
    endtask

    task automatic send_frame(input bit write, input slave_id_t id, input bit burst,
                              input addr_t addr);
        logic [FRAME_LEN-1:0] frame;
        frame = {START_PATTERN, id, (write ? RW_WRITE : !RW_WRITE), burst, addr};
        for (int i = FRAME_LEN - 1; i >= 0; i--) begin
            control = frame[i];
            step_cycle();
        end
        control = 1'b0;
    endtask

    task automatic send_words(input int idx);
        word_t data;
        int    addr;
        // the controller takes its first data bit two edges after the last frame bit
        step_cycle();
        for (int w = 0; w < words_q[idx]; w++) begin
            data = take_bits(DATA_WIDTH);
            addr = (int'(addr_q[idx]) + w) % MEM_DEPTH;
            if (id_q[idx] == SLAVE_ID) begin
                ref_mem[addr]   = data;
                ref_known[addr] = 1'b1;
            end
            for (int b = DATA_WIDTH - 1; b >= 0; b--) begin
                if (gap_q[idx] && take_bits(2) == 32'd3) begin
                    valid = 1'b0;
                    step_cycle();
                end
                valid   = 1'b1;
                wr_data = data[b];
                last    = (w == words_q[idx] - 1) && (b == 0);
                step_cycle();
            end
        end
        valid   = 1'b0;
        wr_data = 1'b0;
        last    = 1'b0;
    endtask

    task automatic collect_read(input string name, input int start, input int words);
        word_t got;
        int    wait_cnt;
        int    addr;
        wait_cnt = 0;
        while (!ready && wait_cnt < 16) begin
            step_cycle();
            wait_cnt++;
        end
        check_value({name, " latency"}, LATENCY, wait_cnt);
        for (int w = 0; w < words; w++) begin
            if (w > 0) begin
                wait_cnt = 0;
                while (!ready && wait_cnt < 8) begin
                    step_cycle();
                    wait_cnt++;
                end
                check_value({name, " word gap"}, WORD_GAP, wait_cnt);
            end
            addr = (start + w) % MEM_DEPTH;
            if (!ref_known[addr]) begin
                stop_run($sformatf("%s reads address %0d, which was never written", name, addr));
            end
            for (int b = DATA_WIDTH - 1; b >= 0; b--) begin
                check_value({name, " ready"}, 1, word_t'(ready));
                got[b] = rd_data;
                // last goes out with the final bit of the final word
                last = (w == words - 1) && (b == 0);
                step_cycle();
            end
            last = 1'b0;
            check_value({name, " data"}, ref_mem[addr], got);
        end
        // transfer has ended, ready stays low
        repeat (3) begin
            check_value({name, " ready after end"}, 0, word_t'(ready));
            step_cycle();
        end
    endtask

    task automatic run_entry(input int idx);
        int addr;
        if (write_q[idx]) begin
            send_frame(1'b1, id_q[idx], burst_q[idx], addr_q[idx]);
            send_words(idx);
            repeat (3) step_cycle();
        end else if (burst_q[idx]) begin
            send_frame(1'b0, id_q[idx], 1'b1, addr_q[idx]);
            collect_read(name_q[idx], int'(addr_q[idx]), words_q[idx]);
        end else begin
            // single reads walk the addresses with one frame per word
            for (int w = 0; w < words_q[idx]; w++) begin
                addr = (int'(addr_q[idx]) + w) % MEM_DEPTH;
                send_frame(1'b0, id_q[idx], 1'b0, addr_t'(addr));
                collect_read(name_q[idx], addr, 1);
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        control     = 1'b0;
        wr_data     = 1'b0;
        valid       = 1'b0;
        last        = 1'b0;
        lfsr_state  = 32'h19d3;
        cycle_cnt   = 0;
        cycle_limit = 0;

        //        name                 write id     burst addr    words gap
        add_entry("single_wr_10",      1'b1, 2'd1, 1'b0, 8'd10,  1,    1'b0);
        add_entry("single_rd_10",      1'b0, 2'd1, 1'b0, 8'd10,  1,    1'b0);
        add_entry("wr_other_id",       1'b1, 2'd2, 1'b0, 8'd10,  1,    1'b0);
        add_entry("rd_after_other_id", 1'b0, 2'd1, 1'b0, 8'd10,  1,    1'b0);
        add_entry("burst_wr_40",       1'b1, 2'd1, 1'b1, 8'd40,  4,    1'b0);
        add_entry("single_rd_40",      1'b0, 2'd1, 1'b0, 8'd40,  4,    1'b0);
        add_entry("burst_wr_wrap",     1'b1, 2'd1, 1'b1, 8'd254, 4,    1'b0);
        add_entry("single_rd_wrap",    1'b0, 2'd1, 1'b0, 8'd254, 4,    1'b0);
        add_entry("burst_rd_40",       1'b0, 2'd1, 1'b1, 8'd40,  3,    1'b0);
        add_entry("burst_rd_wrap",     1'b0, 2'd1, 1'b1, 8'd255, 3,    1'b0);
        add_entry("gap_wr_100",        1'b1, 2'd1, 1'b1, 8'd100, 3,    1'b1);
        add_entry("gap_rd_100",        1'b0, 2'd1, 1'b1, 8'd100, 3,    1'b0);
        add_entry("gap_single_wr_7",   1'b1, 2'd1, 1'b0, 8'd7,   1,    1'b1);
        add_entry("single_rd_7",       1'b0, 2'd1, 1'b0, 8'd7,   1,    1'b0);

        foreach (name_q[i]) begin
            cycle_limit += FRAME_LEN + words_q[i] * (DATA_WIDTH + 4) + 10;
        end
        cycle_limit *= 2;

        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;
        repeat (2) step_cycle();

        foreach (name_q[i]) begin
            run_entry(i);
        end

        // any failed check has already ended the run
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule : bus_slave_tb
